/* verilog/common_pkg.sv */
// Assumes an 8-bit Wishbone bus with 12-bit addresses; the register map and the address map are fixed here
package common_pkg;

    localparam int DATA_WIDTH     = 8;      // Wishbone data width
    localparam int WB_ADDR_WIDTH  = 12;     // Wishbone address width
    localparam int REG_ADDR_WIDTH = 3;      // Register index width
    localparam int REG_COUNT      = 8;
    localparam int RAM_ADDR_WIDTH = 8;      // 256-byte scratch RAM

    // Register indices, 3 to 7 are plain storage
    localparam int REG_STATUS = 0;
    localparam int REG_CPU    = 1;
    localparam int REG_VIDEO  = 2;

    // Status register bits
    localparam int REG_STATUS_GRAPHICS_BIT = 0;   // VIA CA2 (0 = graphics, 1 = text)
    localparam int REG_STATUS_CRT_BIT      = 1;   // Display type
    localparam int REG_STATUS_KEYBOARD_BIT = 2;   // Keyboard type

    // CPU register bits
    localparam int REG_CPU_READY_BIT = 0;
    localparam int REG_CPU_RESET_BIT = 1;
    localparam int REG_CPU_NMI_BIT   = 2;

    // Video register bits
    localparam int REG_VIDEO_COL_80_BIT = 0;
    localparam int REG_VIDEO_MASK_LSB   = 2;      // Mask sits in bits 3:2

    // Address map, anything else is unmapped
    localparam logic [WB_ADDR_WIDTH-1:0] REGS_BASE = 12'h000;
    localparam logic [WB_ADDR_WIDTH-1:0] RAM_BASE  = 12'h800;

    // Opcode in bits 7:6 of the first frame byte
    typedef enum logic [1:0] {
        OP_NONE  = 2'b00,
        OP_WRITE = 2'b01,
        OP_READ  = 2'b10
    } spi_op_e;

    // Request shared by all bus targets
    typedef struct packed {
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]    data;
        logic                     we;
    } wb_req_t;

    typedef struct packed {
        logic video_graphic;
        logic config_crt;
        logic config_keyboard;
    } status_in_t;

    typedef struct packed {
        logic ready;
        logic reset;
        logic nmi;
    } cpu_ctl_t;

    typedef struct packed {
        logic       col_80;
        logic [1:0] ram_mask;   // Video RAM address bits 11:10
    } video_ctl_t;

endpackage

/* verilog/spi_target.sv */
// SPI mode 0 target, MSB first; SCLK must stay below one eighth of wb_clock_i
`timescale 1ns/100ps

module spi_target import common_pkg::*; (
    input  logic                  wb_clock_i,
    input  logic                  arst_n_i,
    input  logic                  spi_sclk_i,
    input  logic                  spi_cs_n_i,
    input  logic                  spi_mosi_i,
    output logic                  spi_miso_o,
    input  logic [DATA_WIDTH-1:0] tx_byte_i,      // Byte for the next SPI byte
    input  logic                  tx_load_i,
    output logic [DATA_WIDTH-1:0] rx_byte_o,
    output logic                  rx_valid_o,     // One cycle per complete byte
    output logic                  frame_start_o,  // CS falling
    output logic                  frame_end_o     // CS rising
);
    logic [2:0]                    sclk_q;     // Two sync stages plus edge history
    logic [2:0]                    cs_n_q;
    logic [1:0]                    mosi_q;     // Aligned with sclk_q[1]
    logic [$clog2(DATA_WIDTH)-1:0] bit_cnt;    // Bits seen in current byte
    logic [DATA_WIDTH-1:0]         rx_shift;
    logic [DATA_WIDTH-1:0]         tx_shift;
    logic                          sclk_rise;
    logic                          sclk_fall;
    logic                          cs_active;

    assign sclk_rise     = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall     = ~sclk_q[1] & sclk_q[2];
    assign cs_active     = ~cs_n_q[1];
    assign frame_start_o = ~cs_n_q[1] & cs_n_q[2];
    assign frame_end_o   = cs_n_q[1] & ~cs_n_q[2];
    assign spi_miso_o    = tx_shift[DATA_WIDTH-1];   // MSB first
    assign rx_byte_o     = rx_shift;

    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sclk_q     <= '0;                  // Mode 0 idles low
            cs_n_q     <= '1;                  // Deselected
            mosi_q     <= '0;
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
            tx_shift   <= '0;
        end else begin
            sclk_q     <= {sclk_q[1:0], spi_sclk_i};
            cs_n_q     <= {cs_n_q[1:0], spi_cs_n_i};
            mosi_q     <= {mosi_q[0], spi_mosi_i};
            rx_valid_o <= 1'b0;

            if (frame_end_o) begin
                bit_cnt <= '0;                 // Partial byte dropped
            end else if (sclk_rise && cs_active) begin
                bit_cnt    <= bit_cnt + 1'b1;
                rx_valid_o <= (bit_cnt == '1);  // Eighth bit sampled
            end

            // MISO reads 0 until the bus master loads a byte
            if (frame_start_o) begin
                tx_shift <= '0;
            end else if (tx_load_i) begin
                tx_shift <= tx_byte_i;
            end else if (sclk_fall && cs_active && bit_cnt != '0) begin
                tx_shift <= {tx_shift[DATA_WIDTH-2:0], 1'b0};  // Hold across byte boundary
            end
        end
    end

    // Sample MOSI on rising SCLK
    always_ff @(posedge wb_clock_i) begin
        if (sclk_rise && cs_active) begin
            rx_shift <= {rx_shift[DATA_WIDTH-2:0], mosi_q[1]};
        end
    end

endmodule

/* verilog/spi_bus_master.sv */
// One Wishbone single transfer per three-byte SPI frame; short frames are dropped, no bursts
`timescale 1ns/100ps

module spi_bus_master import common_pkg::*; (
    input  logic                  wb_clock_i,
    input  logic                  arst_n_i,
    input  logic [DATA_WIDTH-1:0] rx_byte_i,
    input  logic                  rx_valid_i,
    input  logic                  frame_start_i,
    input  logic                  frame_end_i,
    output logic [DATA_WIDTH-1:0] tx_byte_o,      // Read data for MISO
    output logic                  tx_load_o,
    output wb_req_t               wb_req_o,
    output logic                  wb_cycle_o,
    output logic                  wb_strobe_o,
    output logic                  regs_sel_o,
    output logic                  ram_sel_o,
    input  logic [DATA_WIDTH-1:0] regs_data_i,
    input  logic                  regs_ack_i,
    input  logic [DATA_WIDTH-1:0] ram_data_i,
    input  logic                  ram_ack_i
);
    typedef enum logic [2:0] {IDLE, OPCODE, ADDR, DATA, BUS, DONE} state_e;

    state_e                   state_q;
    spi_op_e                  op_q;
    logic [WB_ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0]    data_q;
    logic                     issued_q;   // Strobe already accepted, no stall
    logic                     regs_hit;
    logic                     ram_hit;
    logic                     bus_ack;

    // Region decode on upper address bits
    assign regs_hit = addr_q[WB_ADDR_WIDTH-1:REG_ADDR_WIDTH]
                      == REGS_BASE[WB_ADDR_WIDTH-1:REG_ADDR_WIDTH];
    assign ram_hit  = addr_q[WB_ADDR_WIDTH-1:RAM_ADDR_WIDTH]
                      == RAM_BASE[WB_ADDR_WIDTH-1:RAM_ADDR_WIDTH];
    assign bus_ack  = regs_ack_i | ram_ack_i;

    // No cycle for unmapped addresses
    assign wb_cycle_o  = (state_q == BUS) && (regs_hit || ram_hit);
    assign wb_strobe_o = wb_cycle_o && !issued_q;
    assign regs_sel_o  = wb_cycle_o && regs_hit;
    assign ram_sel_o   = wb_cycle_o && ram_hit;

    assign wb_req_o.addr = addr_q;
    assign wb_req_o.data = data_q;
    assign wb_req_o.we   = (op_q == OP_WRITE);
    assign tx_load_o     = (state_q == DONE) && (op_q == OP_READ);

    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= IDLE;
            op_q     <= OP_NONE;
            issued_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: if (frame_start_i) state_q <= OPCODE;
                OPCODE: begin
                    if (frame_end_i) begin
                        state_q <= IDLE;
                    end else if (rx_valid_i) begin
                        op_q    <= spi_op_e'(rx_byte_i[DATA_WIDTH-1 -: 2]);
                        state_q <= ADDR;
                    end
                end
                ADDR: begin
                    if (frame_end_i) begin
                        state_q <= IDLE;
                    end else if (rx_valid_i) begin
                        // Reads go out early so MISO is ready for byte 2
                        case (op_q)
                            OP_READ:  state_q <= BUS;
                            OP_WRITE: state_q <= DATA;
                            default:  state_q <= DONE;   // Ignore rest of frame
                        endcase
                    end
                end
                DATA: begin
                    if (frame_end_i) begin
                        state_q <= IDLE;
                    end else if (rx_valid_i) begin
                        state_q <= BUS;
                    end
                end
                BUS: begin
                    issued_q <= 1'b1;
                    if (bus_ack || !(regs_hit || ram_hit)) begin
                        issued_q <= 1'b0;
                        state_q  <= DONE;
                    end
                end
                DONE:    state_q <= IDLE;   // tx_load for reads
                default: state_q <= IDLE;
            endcase
        end
    end

    // Frame payload and read data
    always_ff @(posedge wb_clock_i) begin
        if (rx_valid_i && state_q == OPCODE) begin
            addr_q[WB_ADDR_WIDTH-1:DATA_WIDTH] <= rx_byte_i[WB_ADDR_WIDTH-DATA_WIDTH-1:0];
        end
        if (rx_valid_i && state_q == ADDR) addr_q[DATA_WIDTH-1:0] <= rx_byte_i;
        if (rx_valid_i && state_q == DATA) data_q <= rx_byte_i;
        if (state_q == BUS) begin
            tx_byte_o <= regs_ack_i ? regs_data_i : (ram_ack_i ? ram_data_i : '0);  // Unmapped reads 0
        end
    end

    // Strobe is a single pulse and the cycle stays open for the ack
    a_stb_pulse: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        wb_strobe_o |=> wb_cycle_o && !wb_strobe_o);

    a_one_sel: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        !(regs_sel_o && ram_sel_o));

    // Request held until the selected target answers
    a_req_stable: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        wb_cycle_o && !bus_ack |=> $stable(wb_req_o));

endmodule

/* verilog/register_file.sv */
// Single-cycle Wishbone register file; a host write to the status register is lost on the next idle cycle
`timescale 1ns/100ps

module register_file import common_pkg::*; (
    input  logic                  wb_clock_i,
    input  logic                  arst_n_i,
    input  wb_req_t               wb_req_i,
    output logic [DATA_WIDTH-1:0] wb_data_o,
    input  logic                  wb_cycle_i,
    input  logic                  wb_strobe_i,
    input  logic                  wb_sel_i,       // Address decoded by bus master
    output logic                  wb_stall_o,
    output logic                  wb_ack_o,
    input  status_in_t            status_i,       // Board inputs
    output cpu_ctl_t              cpu_ctl_o,
    output video_ctl_t            video_ctl_o
);
    logic [DATA_WIDTH-1:0]     regs [REG_COUNT];
    logic [REG_ADDR_WIDTH-1:0] reg_idx;
    logic                      req_hit;
    logic [DATA_WIDTH-1:0]     status_word;

    assign wb_stall_o = 1'b0;   // Always accepts
    assign reg_idx    = wb_req_i.addr[REG_ADDR_WIDTH-1:0];
    assign req_hit    = wb_cycle_i && wb_strobe_i && wb_sel_i;

    // Board inputs placed at their status bits, upper bits zero
    always_comb begin
        status_word                          = '0;
        status_word[REG_STATUS_GRAPHICS_BIT] = status_i.video_graphic;
        status_word[REG_STATUS_CRT_BIT]      = status_i.config_crt;
        status_word[REG_STATUS_KEYBOARD_BIT] = status_i.config_keyboard;
    end

    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            regs[REG_CPU][REG_CPU_RESET_BIT] <= 1'b1;   // CPU held in reset, not ready
        end else begin
            wb_ack_o <= req_hit;
            if (req_hit) begin
                if (wb_req_i.we) regs[reg_idx] <= wb_req_i.data;
            end else begin
                regs[REG_STATUS] <= status_word;   // Refresh while idle
            end
        end
    end

    // Read data is the value before any write in the same cycle
    always_ff @(posedge wb_clock_i) begin
        if (req_hit) wb_data_o <= regs[reg_idx];
    end

    assign cpu_ctl_o.ready = regs[REG_CPU][REG_CPU_READY_BIT];
    assign cpu_ctl_o.reset = regs[REG_CPU][REG_CPU_RESET_BIT];
    assign cpu_ctl_o.nmi   = regs[REG_CPU][REG_CPU_NMI_BIT];

    assign video_ctl_o.col_80   = regs[REG_VIDEO][REG_VIDEO_COL_80_BIT];
    assign video_ctl_o.ram_mask = regs[REG_VIDEO][REG_VIDEO_MASK_LSB +: 2];

    // Ack lands while the cycle is open and no second strobe follows
    a_ack_single: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        wb_ack_o |-> wb_cycle_i && !(wb_strobe_i && wb_sel_i));

endmodule

/* verilog/scratch_ram.sv */
// 256-byte Wishbone RAM with a one-cycle ack; contents are undefined after reset
`timescale 1ns/100ps

module scratch_ram import common_pkg::*; (
    input  logic                  wb_clock_i,
    input  logic                  arst_n_i,
    input  wb_req_t               wb_req_i,
    output logic [DATA_WIDTH-1:0] wb_data_o,
    input  logic                  wb_cycle_i,
    input  logic                  wb_strobe_i,
    input  logic                  wb_sel_i,
    output logic                  wb_ack_o
);
    logic [DATA_WIDTH-1:0]     mem [2**RAM_ADDR_WIDTH];
    logic [RAM_ADDR_WIDTH-1:0] word_addr;
    logic                      req_hit;

    assign word_addr = wb_req_i.addr[RAM_ADDR_WIDTH-1:0];   // Low 8 bits only
    assign req_hit   = wb_cycle_i && wb_strobe_i && wb_sel_i;

    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req_hit;   // Ack one cycle after strobe
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (req_hit) begin
            wb_data_o <= mem[word_addr];        // Old contents on a write
            if (wb_req_i.we) begin
                mem[word_addr] <= wb_req_i.data;
            end
        end
    end

endmodule

/* verilog/pet_ctl_top.sv */
// PET control block top; SPI host must keep SCLK below one eighth of wb_clock_i
`timescale 1ns/100ps

module pet_ctl_top import common_pkg::*; (
    input  logic         wb_clock_i,
    input  logic         arst_n_i,
    input  logic         spi_sclk_i,
    input  logic         spi_cs_n_i,
    input  logic         spi_mosi_i,
    output logic         spi_miso_o,
    input  logic         video_graphic_i,      // VIA CA2
    input  logic         config_crt_i,
    input  logic         config_keyboard_i,
    output logic         cpu_ready_o,
    output logic         cpu_reset_o,
    output logic         cpu_nmi_o,
    output logic         video_col_80_mode_o,
    output logic [11:10] video_ram_mask_o
);
    logic [DATA_WIDTH-1:0] rx_byte;
    logic                  rx_valid;
    logic                  frame_start;
    logic                  frame_end;
    logic [DATA_WIDTH-1:0] tx_byte;
    logic                  tx_load;
    wb_req_t               wb_req;         // Shared by both targets
    logic                  wb_cycle;
    logic                  wb_strobe;
    logic                  regs_sel;
    logic                  ram_sel;
    logic [DATA_WIDTH-1:0] regs_data;
    logic                  regs_ack;
    logic [DATA_WIDTH-1:0] ram_data;
    logic                  ram_ack;
    status_in_t            status;
    cpu_ctl_t              cpu_ctl;
    video_ctl_t            video_ctl;

    assign status = '{video_graphic: video_graphic_i, config_crt: config_crt_i,
                      config_keyboard: config_keyboard_i};

    assign cpu_ready_o         = cpu_ctl.ready;
    assign cpu_reset_o         = cpu_ctl.reset;
    assign cpu_nmi_o           = cpu_ctl.nmi;
    assign video_col_80_mode_o = video_ctl.col_80;
    assign video_ram_mask_o    = video_ctl.ram_mask;

    spi_target spi0 (.wb_clock_i, .arst_n_i, .spi_sclk_i, .spi_cs_n_i, .spi_mosi_i,
        .spi_miso_o, .tx_byte_i(tx_byte), .tx_load_i(tx_load), .rx_byte_o(rx_byte),
        .rx_valid_o(rx_valid), .frame_start_o(frame_start), .frame_end_o(frame_end));

    spi_bus_master master0 (.wb_clock_i, .arst_n_i, .rx_byte_i(rx_byte),
        .rx_valid_i(rx_valid), .frame_start_i(frame_start), .frame_end_i(frame_end),
        .tx_byte_o(tx_byte), .tx_load_o(tx_load), .wb_req_o(wb_req), .wb_cycle_o(wb_cycle),
        .wb_strobe_o(wb_strobe), .regs_sel_o(regs_sel), .ram_sel_o(ram_sel),
        .regs_data_i(regs_data), .regs_ack_i(regs_ack), .ram_data_i(ram_data),
        .ram_ack_i(ram_ack));

    // Stall is constant 0 and the master never waits on it
    register_file regs0 (.wb_clock_i, .arst_n_i, .wb_req_i(wb_req), .wb_data_o(regs_data),
        .wb_cycle_i(wb_cycle), .wb_strobe_i(wb_strobe), .wb_sel_i(regs_sel), .wb_stall_o(),
        .wb_ack_o(regs_ack), .status_i(status), .cpu_ctl_o(cpu_ctl), .video_ctl_o(video_ctl));

    scratch_ram ram0 (.wb_clock_i, .arst_n_i, .wb_req_i(wb_req), .wb_data_o(ram_data),
        .wb_cycle_i(wb_cycle), .wb_strobe_i(wb_strobe), .wb_sel_i(ram_sel),
        .wb_ack_o(ram_ack));

endmodule

/* bench/tb_spi_tasks.svh */
// Included inside tb_pet_ctl; relies on its pin signals, SCLK_HALF, TIMEOUT_CYCLES and counters
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

function automatic logic [WB_ADDR_WIDTH-1:0] reg_addr(input int idx);
    return REGS_BASE + WB_ADDR_WIDTH'(idx);
endfunction

// One mode 0 byte, MSB first; MISO is sampled half a clock before SCLK rises
task automatic shift_byte(input logic [DATA_WIDTH-1:0] tx, output logic [DATA_WIDTH-1:0] rx);
    for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
        spi_mosi <= tx[i];                                  // Changes while SCLK low
        repeat (SCLK_HALF - 1) @(posedge wb_clock);
        @(negedge wb_clock);
        rx[i] = spi_miso;
        @(posedge wb_clock);
        spi_sclk <= 1'b1;
        repeat (SCLK_HALF) @(posedge wb_clock);
        spi_sclk <= 1'b0;
    end
endtask

// Frame of nbytes bytes, then CS high and a wait for the target to see it
task automatic send_frame(input logic [DATA_WIDTH-1:0] b0, input logic [DATA_WIDTH-1:0] b1,
                          input logic [DATA_WIDTH-1:0] b2, input int nbytes,
                          output logic [DATA_WIDTH-1:0] last_rx);
    logic [3*DATA_WIDTH-1:0] frame;
    int                      wait_cnt;
    frame    = {b0, b1, b2};
    wait_cnt = 0;
    @(posedge wb_clock);
    spi_cs_n <= 1'b0;
    repeat (SCLK_HALF) @(posedge wb_clock);
    for (int k = 0; k < nbytes; k++) begin
        shift_byte(frame[3*DATA_WIDTH-1 - k*DATA_WIDTH -: DATA_WIDTH], last_rx);
        if (k < 2) compare_byte("spi_miso", last_rx, '0);  // MISO idle in command bytes
    end
    repeat (SCLK_HALF) @(posedge wb_clock);
    spi_cs_n <= 1'b1;
    spi_mosi <= 1'b0;
    do begin
        @(negedge wb_clock);
        wait_cnt++;
    end while (!dut0.frame_end && wait_cnt < TIMEOUT_CYCLES);
    if (!dut0.frame_end) begin
        timeouts++;
        $display("Timeout: the SPI target never saw CS rise at the end of a frame");
    end
    repeat (SCLK_HALF) @(posedge wb_clock);                 // Gap between frames
endtask

task automatic spi_write(input logic [WB_ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
    logic [DATA_WIDTH-1:0] unused;
    send_frame({OP_WRITE, 2'b00, addr[11:8]}, addr[7:0], data, 3, unused);
endtask

task automatic spi_read(input logic [WB_ADDR_WIDTH-1:0] addr, output logic [DATA_WIDTH-1:0] data);
    send_frame({OP_READ, 2'b00, addr[11:8]}, addr[7:0], 8'h00, 3, data);  // Data on byte 2
endtask

// Write and track the expected register contents
task automatic write_reg(input int idx, input logic [DATA_WIDTH-1:0] data);
    spi_write(reg_addr(idx), data);
    reg_model[idx] = data;
endtask

task automatic compare_byte(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
        errors++;
        $display("** Error: %s got 8'h%h, expected 8'h%h", name, got, exp);
    end
endtask

// Expected pins taken from the CPU register bits
task automatic compare_cpu(input logic [DATA_WIDTH-1:0] reg_val);
    cpu_ctl_t exp;
    cpu_ctl_t got;
    int       n;
    exp = '{ready: reg_val[REG_CPU_READY_BIT], reset: reg_val[REG_CPU_RESET_BIT],
            nmi: reg_val[REG_CPU_NMI_BIT]};
    n   = 0;
    do begin
        @(negedge wb_clock);
        got = {cpu_ready, cpu_reset, cpu_nmi};
        n++;
    end while (got !== exp && n < TIMEOUT_CYCLES);
    if (got !== exp) begin
        errors++;
        $display("** Error: cpu_ctl got 3'h%h, expected 3'h%h", got, exp);
    end
endtask

task automatic compare_video(input logic [DATA_WIDTH-1:0] reg_val);
    video_ctl_t exp;
    video_ctl_t got;
    int         n;
    exp = '{col_80: reg_val[REG_VIDEO_COL_80_BIT], ram_mask: reg_val[REG_VIDEO_MASK_LSB +: 2]};
    n   = 0;
    do begin
        @(negedge wb_clock);
        got = {video_col_80_mode, video_ram_mask};
        n++;
    end while (got !== exp && n < TIMEOUT_CYCLES);
    if (got !== exp) begin
        errors++;
        $display("** Error: video_ctl got 3'h%h, expected 3'h%h", got, exp);
    end
endtask

`endif

/* bench/tb_pet_ctl.sv */
// Directed testbench; SCLK runs at a tenth of wb_clock_i, so every SPI frame takes about 260 clocks
`timescale 1ns/100ps

module tb_pet_ctl import common_pkg::*; ();
    localparam int SCLK_HALF      = 5;      // Clocks per SCLK half period
    localparam int TIMEOUT_CYCLES = 200;

    logic       wb_clock;
    logic       arst_n;
    logic       spi_sclk;
    logic       spi_cs_n;
    logic       spi_mosi;
    logic       spi_miso;
    logic       video_graphic;
    logic       config_crt;
    logic       config_keyboard;
    logic       cpu_ready;
    logic       cpu_reset;
    logic       cpu_nmi;
    logic       video_col_80_mode;
    logic [1:0] video_ram_mask;

    int errors;                                            // Value mismatches
    int timeouts;
    integer seed;
    logic [DATA_WIDTH-1:0]    reg_model [REG_COUNT];       // Expected register contents
    logic [DATA_WIDTH-1:0]    ram_model [2**RAM_ADDR_WIDTH];
    logic [WB_ADDR_WIDTH-1:0] ram_addrs [$];               // RAM addresses written so far

    `include "tb_spi_tasks.svh"

    pet_ctl_top dut0 (.wb_clock_i(wb_clock), .arst_n_i(arst_n), .spi_sclk_i(spi_sclk),
        .spi_cs_n_i(spi_cs_n), .spi_mosi_i(spi_mosi), .spi_miso_o(spi_miso),
        .video_graphic_i(video_graphic), .config_crt_i(config_crt),
        .config_keyboard_i(config_keyboard), .cpu_ready_o(cpu_ready), .cpu_reset_o(cpu_reset),
        .cpu_nmi_o(cpu_nmi), .video_col_80_mode_o(video_col_80_mode),
        .video_ram_mask_o(video_ram_mask));

    initial begin
        wb_clock = 1'b0;
        forever #10 wb_clock = ~wb_clock;               // 50 MHz
    end

    // Status byte from the board inputs, zeros above bit 2
    function automatic logic [DATA_WIDTH-1:0] expected_status();
        logic [DATA_WIDTH-1:0] s;
        s                          = '0;
        s[REG_STATUS_GRAPHICS_BIT] = video_graphic;
        s[REG_STATUS_CRT_BIT]      = config_crt;
        s[REG_STATUS_KEYBOARD_BIT] = config_keyboard;
        return s;
    endfunction

    task automatic verify_reset_state();
        logic [DATA_WIDTH-1:0] rd;
        compare_cpu(8'h01 << REG_CPU_RESET_BIT);            // Only reset high
        compare_video('0);
        spi_read(reg_addr(REG_CPU), rd);
        compare_byte("reg_cpu", rd, 8'h01 << REG_CPU_RESET_BIT);
    endtask

    task automatic exercise_control_regs();
        logic [DATA_WIDTH-1:0] cpu_vals [2];
        logic [DATA_WIDTH-1:0] video_vals [2];
        logic [DATA_WIDTH-1:0] rd;
        cpu_vals   = '{8'h05, 8'h03};                       // Ready with NMI, then ready in reset
        video_vals = '{8'h0D, 8'h06};                       // 80 col mask 3, then 40 col mask 1
        for (int i = 0; i < 2; i++) begin
            write_reg(REG_CPU, cpu_vals[i]);
            compare_cpu(cpu_vals[i]);
            spi_read(reg_addr(REG_CPU), rd);
            compare_byte("reg_cpu", rd, cpu_vals[i]);
            write_reg(REG_VIDEO, video_vals[i]);
            compare_video(video_vals[i]);
            spi_read(reg_addr(REG_VIDEO), rd);
            compare_byte("reg_video", rd, video_vals[i]);
        end
        for (int r = 3; r < REG_COUNT; r++) begin
            write_reg(r, DATA_WIDTH'(r * 37 + 17));         // Plain storage
        end
        for (int r = 3; r < REG_COUNT; r++) begin
            spi_read(reg_addr(r), rd);
            compare_byte("reg_plain", rd, reg_model[r]);
        end
    endtask

    task automatic read_status_inputs();
        logic [DATA_WIDTH-1:0] rd;
        @(posedge wb_clock);
        video_graphic   <= 1'b1;
        config_crt      <= 1'b0;
        config_keyboard <= 1'b1;
        spi_read(reg_addr(REG_STATUS), rd);
        compare_byte("reg_status", rd, expected_status());
        @(posedge wb_clock);
        video_graphic <= 1'b0;
        config_crt    <= 1'b1;
        spi_write(reg_addr(REG_STATUS), 8'hF8);             // Lost on the next idle cycle
        spi_read(reg_addr(REG_STATUS), rd);
        compare_byte("reg_status", rd, expected_status());
    endtask

    task automatic fill_and_verify_ram();
        logic [RAM_ADDR_WIDTH-1:0] offset;
        logic [DATA_WIDTH-1:0]     wdata;
        logic [DATA_WIDTH-1:0]     rd;
        for (int i = 0; i < 16; i++) begin
            offset = RAM_ADDR_WIDTH'($random(seed));
            wdata  = DATA_WIDTH'($random(seed));
            spi_write(RAM_BASE | WB_ADDR_WIDTH'(offset), wdata);
            ram_model[offset] = wdata;                      // Repeated address keeps last data
            ram_addrs.push_back(RAM_BASE | WB_ADDR_WIDTH'(offset));
        end
        foreach (ram_addrs[i]) begin
            spi_read(ram_addrs[i], rd);
            compare_byte("ram_data", rd, ram_model[ram_addrs[i][RAM_ADDR_WIDTH-1:0]]);
        end
    endtask

    task automatic probe_unmapped();
        logic [DATA_WIDTH-1:0] rd;
        spi_read(12'h400, rd);
        compare_byte("unmapped_read", rd, 8'h00);
        spi_write(12'h403, ~reg_model[3]);                  // Low bits alias register 3
        spi_write(12'h400 | {4'h0, ram_addrs[0][7:0]},      // Low bits alias RAM
                  ~ram_model[ram_addrs[0][RAM_ADDR_WIDTH-1:0]]);
        spi_read(reg_addr(3), rd);
        compare_byte("reg_plain", rd, reg_model[3]);
        spi_read(ram_addrs[0], rd);
        compare_byte("ram_data", rd, ram_model[ram_addrs[0][RAM_ADDR_WIDTH-1:0]]);
        compare_cpu(reg_model[REG_CPU]);
    endtask

    task automatic abort_write_frame();
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]    rd;
        addr = reg_addr(7);
        send_frame({OP_WRITE, 2'b00, addr[11:8]}, addr[7:0], 8'hC3, 2, rd);
        spi_read(reg_addr(7), rd);
        compare_byte("reg_plain", rd, reg_model[7]);
    endtask

    initial begin
        seed            = 32'hff306ff9;
        errors          = 0;
        timeouts        = 0;
        arst_n          = 1'b0;
        spi_sclk        = 1'b0;                             // Mode 0 idle
        spi_cs_n        = 1'b1;
        spi_mosi        = 1'b0;
        video_graphic   = 1'b0;
        config_crt      = 1'b0;
        config_keyboard = 1'b0;
        repeat (2) @(posedge wb_clock);
        arst_n <= 1'b1;

        verify_reset_state();
        exercise_control_regs();
        read_status_inputs();
        fill_and_verify_ram();
        probe_unmapped();
        abort_write_frame();

        $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+bench
verilog/common_pkg.sv
verilog/spi_target.sv
verilog/spi_bus_master.sv
verilog/register_file.sv
verilog/scratch_ram.sv
verilog/pet_ctl_top.sv
bench/tb_pet_ctl.sv

/* Bender.yml */
package:
  name: pet_ctl

sources:
  - files:
      - verilog/common_pkg.sv
      - verilog/spi_target.sv
      - verilog/spi_bus_master.sv
      - verilog/register_file.sv
      - verilog/scratch_ram.sv
      - verilog/pet_ctl_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_pet_ctl.sv
